/* rtl/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit import rvIsaPkg::*, decodeCtrlPkg::*; (
    input  opcode_t  opcode_i,
    input  funct3_t  funct3_i,
    input  logic     funct7b5_i,
    output ctrlSig_t ctrl_o,
    output immSrc_t  immSrc_o
);

    aluCtrl_t aluOp;
    logic     aluValid;

    // ALU decode, shared by OP and OP_IMM
    always_comb begin
        aluValid = 1'b1;
        case (funct3_i)
            F3_ADD_SUB: aluOp = (funct7b5_i && opcode_i == OPC_OP) ? ALU_SUB : ALU_ADD;
            F3_SLL:     aluOp = ALU_SLL;
            F3_SLT:     aluOp = ALU_SLT;
            F3_XOR:     aluOp = ALU_XOR;
            F3_SRL:     aluOp = ALU_SRL;
            F3_OR:      aluOp = ALU_OR;
            F3_AND:     aluOp = ALU_AND;
            default: begin
                aluOp    = ALU_ADD;
                aluValid = 1'b0;
            end
        endcase
    end

    // Main decoder
    always_comb begin
        ctrl_o   = '0;
        immSrc_o = IMM_I;
        case (opcode_i)
            OPC_OP: begin
                if (aluValid) begin
                    ctrl_o.regWrite   = 1'b1;
                    ctrl_o.resultSrc  = RES_ALU;
                    ctrl_o.aluControl = aluOp;
                end
            end
            OPC_OP_IMM: begin
                if (aluValid) begin
                    ctrl_o.regWrite   = 1'b1;
                    ctrl_o.resultSrc  = RES_ALU;
                    ctrl_o.aluControl = aluOp;
                    ctrl_o.aluSrc     = 1'b1;
                end
            end
            OPC_LOAD: begin
                ctrl_o.regWrite   = 1'b1;
                ctrl_o.resultSrc  = RES_MEM;
                ctrl_o.aluControl = ALU_ADD;
                ctrl_o.aluSrc     = 1'b1;
            end
            OPC_STORE: begin
                case (funct3_i)
                    F3_SB:   ctrl_o.memWrite = STW_BYTE;
                    F3_SH:   ctrl_o.memWrite = STW_HALF;
                    F3_SW:   ctrl_o.memWrite = STW_WORD;
                    default: ctrl_o.memWrite = STW_NONE;
                endcase
                // Address is rs1 + S immediate
                if (ctrl_o.memWrite != STW_NONE) begin
                    ctrl_o.aluControl = ALU_ADD;
                    ctrl_o.aluSrc     = 1'b1;
                    immSrc_o          = IMM_S;
                end
            end
            OPC_BRANCH: begin
                ctrl_o.branch     = 1'b1;
                ctrl_o.aluControl = ALU_SUB;
                immSrc_o          = IMM_B;
            end
            OPC_JAL: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.resultSrc = RES_PC_PLUS4;
                ctrl_o.jump      = JMP_JAL;
                immSrc_o         = IMM_J;
            end
            OPC_JALR: begin
                ctrl_o.regWrite   = 1'b1;
                ctrl_o.resultSrc  = RES_PC_PLUS4;
                ctrl_o.jump       = JMP_JALR;
                ctrl_o.aluControl = ALU_ADD;
                ctrl_o.aluSrc     = 1'b1;
            end
            default: ;
        endcase
    end

    // Store lanes must never overlap
    always_comb begin
        assert ($onehot0(ctrl_o.memWrite))
            else $error("controlUnit: memWrite not one-hot: %b", ctrl_o.memWrite);
    end

endmodule

`default_nettype wire

/* rtl/decodeCtrlPkg.sv */
`default_nettype none

package decodeCtrlPkg;

    import rvIsaPkg::*;

    typedef logic [2:0] aluCtrl_t;
    typedef logic [1:0] resultSrc_t;
    typedef logic [2:0] storeWidth_t;
    typedef logic [1:0] jumpKind_t;
    typedef logic [1:0] immSrc_t;

    localparam aluCtrl_t ALU_ADD = 3'd0;
    localparam aluCtrl_t ALU_SUB = 3'd1;
    localparam aluCtrl_t ALU_AND = 3'd2;
    localparam aluCtrl_t ALU_OR  = 3'd3;
    localparam aluCtrl_t ALU_XOR = 3'd4;
    localparam aluCtrl_t ALU_SLT = 3'd5;
    localparam aluCtrl_t ALU_SLL = 3'd6;
    localparam aluCtrl_t ALU_SRL = 3'd7;

    localparam resultSrc_t RES_ALU      = 2'd0;
    localparam resultSrc_t RES_MEM      = 2'd1;
    localparam resultSrc_t RES_PC_PLUS4 = 2'd2;

    // One-hot byte lane width of a store
    localparam storeWidth_t STW_NONE = 3'b000;
    localparam storeWidth_t STW_BYTE = 3'b001;
    localparam storeWidth_t STW_HALF = 3'b010;
    localparam storeWidth_t STW_WORD = 3'b100;

    localparam jumpKind_t JMP_NONE = 2'd0;
    localparam jumpKind_t JMP_JAL  = 2'd1;
    localparam jumpKind_t JMP_JALR = 2'd2;

    localparam immSrc_t IMM_I = 2'd0;
    localparam immSrc_t IMM_S = 2'd1;
    localparam immSrc_t IMM_B = 2'd2;
    localparam immSrc_t IMM_J = 2'd3;

    typedef struct packed {
        logic        regWrite;
        resultSrc_t  resultSrc;
        storeWidth_t memWrite;
        jumpKind_t   jump;
        logic        branch;
        aluCtrl_t    aluControl;
        logic        aluSrc;
    } ctrlSig_t;

    // Everything the execute stage needs from decode
    typedef struct packed {
        ctrlSig_t ctrl;
        xlen_t    rd1;
        xlen_t    rd2;
        xlen_t    immExt;
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
    } idExBundle_t;

endpackage

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import rvIsaPkg::*, decodeCtrlPkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  instr_t      instrD_i,
    input  xlen_t       resultW_i,
    input  regAddr_t    rdW_i,
    input  logic        regWriteW_i,
    input  logic        stallE_i,
    input  logic        flushE_i,
    output idExBundle_t idExE_o,
    output regAddr_t    rs1D_o,
    output regAddr_t    rs2D_o,
    output xlen_t       a0_o
);

    idExBundle_t bundleD;

    decodeUnit decodeUnit_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .instrD_i    (instrD_i),
        .resultW_i   (resultW_i),
        .rdW_i       (rdW_i),
        .regWriteW_i (regWriteW_i),
        .bundleD_o   (bundleD),
        .rs1D_o      (rs1D_o),
        .rs2D_o      (rs2D_o),
        .a0_o        (a0_o)
    );

    idExRegister idExRegister_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .stall_i   (stallE_i),
        .flush_i   (flushE_i),
        .bundleD_i (bundleD),
        .bundleE_o (idExE_o)
    );

endmodule

`default_nettype wire

/* rtl/decodeUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeUnit import rvIsaPkg::*, decodeCtrlPkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  instr_t      instrD_i,
    // Write-back port from W
    input  xlen_t       resultW_i,
    input  regAddr_t    rdW_i,
    input  logic        regWriteW_i,
    output idExBundle_t bundleD_o,
    // To hazard unit
    output regAddr_t    rs1D_o,
    output regAddr_t    rs2D_o,
    output xlen_t       a0_o
);

    opcode_t  opcode;
    funct3_t  funct3;
    logic     funct7b5;
    regAddr_t rdD;
    ctrlSig_t ctrl;
    immSrc_t  immSrc;
    xlen_t    rd1;
    xlen_t    rd2;
    xlen_t    immExt;

    // Instruction fields
    assign opcode   = instrD_i[6:0];
    assign funct3   = instrD_i[14:12];
    assign funct7b5 = instrD_i[30];
    assign rdD      = instrD_i[11:7];
    assign rs1D_o   = instrD_i[19:15];
    assign rs2D_o   = instrD_i[24:20];

    controlUnit controlUnit_i (
        .opcode_i   (opcode),
        .funct3_i   (funct3),
        .funct7b5_i (funct7b5),
        .ctrl_o     (ctrl),
        .immSrc_o   (immSrc)
    );

    regFile regFile_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .rs1_i       (rs1D_o),
        .rs2_i       (rs2D_o),
        .rd_i        (rdW_i),
        .writeData_i (resultW_i),
        .regWrite_i  (regWriteW_i),
        .rd1_o       (rd1),
        .rd2_o       (rd2),
        .a0_o        (a0_o)
    );

    immExtend immExtend_i (
        .instr_i  (instrD_i),
        .immSrc_i (immSrc),
        .immExt_o (immExt)
    );

    assign bundleD_o = '{
        ctrl:   ctrl,
        rd1:    rd1,
        rd2:    rd2,
        immExt: immExt,
        rd:     rdD,
        rs1:    rs1D_o,
        rs2:    rs2D_o
    };

endmodule

`default_nettype wire

/* rtl/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path width
`define XLEN_W      32

// Register file shape, fixed by RV32I
`define REG_ADDR_W  5
`define NUM_REGS    32

// ABI return value register, exported for debug
`define A0_INDEX    10

`endif

/* rtl/idExRegister.sv */
`timescale 1ns/10ps
`default_nettype none

module idExRegister import decodeCtrlPkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  idExBundle_t bundleD_i,
    output idExBundle_t bundleE_o
);

    // Priority is reset, then flush, then stall
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bundleE_o <= '0;
        end else if (flush_i) begin
            // Bubble, all control inactive
            bundleE_o <= '0;
        end else if (!stall_i) begin
            bundleE_o <= bundleD_i;
        end
    end

    a_stallHolds : assert property (
        @(posedge clk) disable iff (reset_i)
        (stall_i && !flush_i) |=> $stable(bundleE_o)
    ) else $error("idExRegister: output changed during stall");

endmodule

`default_nettype wire

/* rtl/immExtend.sv */
`timescale 1ns/10ps
`default_nettype none

module immExtend import rvIsaPkg::*, decodeCtrlPkg::*; (
    input  instr_t  instr_i,
    input  immSrc_t immSrc_i,
    output xlen_t   immExt_o
);

    logic signBit;

    assign signBit = instr_i[31];

    always_comb begin
        unique case (immSrc_i)
            IMM_I: immExt_o = {{20{signBit}}, instr_i[31:20]};
            IMM_S: immExt_o = {{20{signBit}}, instr_i[31:25], instr_i[11:7]};
            // Branch offset is halfword aligned
            IMM_B: immExt_o = {{20{signBit}}, instr_i[7], instr_i[30:25],
                               instr_i[11:8], 1'b0};
            // Jump offset also halfword aligned
            IMM_J: immExt_o = {{12{signBit}}, instr_i[19:12], instr_i[20],
                               instr_i[30:21], 1'b0};
        endcase
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module regFile import rvIsaPkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  regAddr_t rs1_i,
    input  regAddr_t rs2_i,
    input  regAddr_t rd_i,
    input  xlen_t    writeData_i,
    input  logic     regWrite_i,
    output xlen_t    rd1_o,
    output xlen_t    rd2_o,
    output xlen_t    a0_o
);

    xlen_t regs [`NUM_REGS];
    logic  wrActive;

    // x0 is never written
    assign wrActive = regWrite_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrActive) begin
            regs[rd_i] <= writeData_i;
        end
    end

    // Write-through so W-stage results are seen in the same cycle
    assign rd1_o = (rs1_i == '0) ? '0 :
                   (wrActive && rs1_i == rd_i) ? writeData_i : regs[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 :
                   (wrActive && rs2_i == rd_i) ? writeData_i : regs[rs2_i];
    assign a0_o  = (wrActive && rd_i == regAddr_t'(`A0_INDEX)) ? writeData_i
                                                                : regs[`A0_INDEX];

    a_x0ReadsZero : assert property (
        @(posedge clk) disable iff (reset_i)
        ((rs1_i == '0) |-> (rd1_o == '0)) and ((rs2_i == '0) |-> (rd2_o == '0))
    ) else $error("regFile: x0 read returned nonzero");

endmodule

`default_nettype wire

/* rtl/rvIsaPkg.sv */
`default_nettype none

`include "decode_params.svh"

package rvIsaPkg;

    typedef logic [31:0]              instr_t;
    typedef logic [`XLEN_W-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0]   regAddr_t;
    typedef logic [6:0]               opcode_t;
    typedef logic [2:0]               funct3_t;

    // Major opcodes of the supported subset
    localparam opcode_t OPC_OP      = 7'b0110011;
    localparam opcode_t OPC_OP_IMM  = 7'b0010011;
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_JAL     = 7'b1101111;
    localparam opcode_t OPC_JALR    = 7'b1100111;

    // funct3 for OP and OP_IMM
    localparam funct3_t F3_ADD_SUB  = 3'd0;
    localparam funct3_t F3_SLL      = 3'd1;
    localparam funct3_t F3_SLT      = 3'd2;
    localparam funct3_t F3_XOR      = 3'd4;
    localparam funct3_t F3_SRL      = 3'd5;
    localparam funct3_t F3_OR       = 3'd6;
    localparam funct3_t F3_AND      = 3'd7;

    // funct3 for stores
    localparam funct3_t F3_SB       = 3'd0;
    localparam funct3_t F3_SH       = 3'd1;
    localparam funct3_t F3_SW       = 3'd2;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module decodeStageTb -o decodeStageTb

./obj_dir/decodeStageTb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* src.f */
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/decodeCtrlPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/immExtend.sv
rtl/decodeUnit.sv
rtl/idExRegister.sv
rtl/decodeStage.sv
tests/decodeStageTb.sv

/* tests/decodeStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_params.svh"

module decodeStageTb import rvIsaPkg::*, decodeCtrlPkg::*;;

    localparam int RANDOM_COUNT    = 300;
    localparam int DIRECTED_CYCLES = 80;
    localparam int TOTAL_CYCLES    = 8 + DIRECTED_CYCLES + RANDOM_COUNT;

    logic        clk = 1'b0;
    logic        reset_i;
    instr_t      instrD_i;
    xlen_t       resultW_i;
    regAddr_t    rdW_i;
    logic        regWriteW_i;
    logic        stallE_i;
    logic        flushE_i;
    idExBundle_t idExE_o;
    regAddr_t    rs1D_o;
    regAddr_t    rs2D_o;
    xlen_t       a0_o;

    // Expected state updated on the rising edge
    xlen_t       regModel [`NUM_REGS];
    idExBundle_t expOut;
    string       testName = "reset";
    string       checkName = "reset";

    decodeStage decodeStage_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .instrD_i    (instrD_i),
        .resultW_i   (resultW_i),
        .rdW_i       (rdW_i),
        .regWriteW_i (regWriteW_i),
        .stallE_i    (stallE_i),
        .flushE_i    (flushE_i),
        .idExE_o     (idExE_o),
        .rs1D_o      (rs1D_o),
        .rs2D_o      (rs2D_o),
        .a0_o        (a0_o)
    );

    always #5 clk = ~clk;

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "decodeStageTb stopped on the first error");
    endtask

    task automatic checkCtrl(string name, ctrlSig_t exp, ctrlSig_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkWord(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkRegAddr(string name, regAddr_t exp, regAddr_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            abortRun();
        end
    endtask

    task automatic compareBundle(string name, idExBundle_t exp, idExBundle_t act);
        checkCtrl({name, " ctrl"}, exp.ctrl, act.ctrl);
        checkWord({name, " rd1"}, exp.rd1, act.rd1);
        checkWord({name, " rd2"}, exp.rd2, act.rd2);
        checkWord({name, " immExt"}, exp.immExt, act.immExt);
        checkRegAddr({name, " rd"}, exp.rd, act.rd);
        checkRegAddr({name, " rs1"}, exp.rs1, act.rs1);
        checkRegAddr({name, " rs2"}, exp.rs2, act.rs2);
    endtask

    // Register read as seen before the edge with the W port bypass
    function automatic xlen_t modelRead(regAddr_t a, logic wrEn, regAddr_t wrAddr, xlen_t wrData);
        if (a == '0)
            return '0;
        if (wrEn && a == wrAddr)
            return wrData;
        return regModel[a];
    endfunction

    function automatic aluCtrl_t aluOpFor(funct3_t f3, logic subtract);
        case (f3)
            3'd0:    return subtract ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic xlen_t immFor(instr_t ins, immSrc_t kind);
        logic signed [31:0] v;
        case (kind)
            IMM_S:   v = 32'($signed({ins[31:25], ins[11:7]}));
            IMM_B:   v = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            IMM_J:   v = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default: v = 32'($signed(ins[31:20]));
        endcase
        return xlen_t'(v);
    endfunction

    // Reference decoder for the supported RV32I subset
    function automatic idExBundle_t decodeRef(instr_t ins, logic wrEn, regAddr_t wrAddr,
                                              xlen_t wrData);
        idExBundle_t b;
        ctrlSig_t    c;
        immSrc_t     kind;
        opcode_t     opc;
        funct3_t     f3;
        opc  = ins[6:0];
        f3   = ins[14:12];
        c    = '0;
        kind = IMM_I;
        if ((opc == OPC_OP || opc == OPC_OP_IMM) && f3 != 3'd3) begin
            c.regWrite   = 1'b1;
            c.resultSrc  = RES_ALU;
            c.aluSrc     = (opc == OPC_OP_IMM);
            c.aluControl = aluOpFor(f3, ins[30] && opc == OPC_OP);
        end else if (opc == OPC_LOAD) begin
            c.regWrite  = 1'b1;
            c.resultSrc = RES_MEM;
            c.aluSrc    = 1'b1;
        end else if (opc == OPC_STORE && f3 <= 3'd2) begin
            c.memWrite = 3'b001 << f3;
            c.aluSrc   = 1'b1;
            kind       = IMM_S;
        end else if (opc == OPC_BRANCH) begin
            c.branch     = 1'b1;
            c.aluControl = ALU_SUB;
            kind         = IMM_B;
        end else if (opc == OPC_JAL || opc == OPC_JALR) begin
            c.regWrite  = 1'b1;
            c.resultSrc = RES_PC_PLUS4;
            c.jump      = (opc == OPC_JAL) ? JMP_JAL : JMP_JALR;
            c.aluSrc    = (opc == OPC_JALR);
            kind        = (opc == OPC_JAL) ? IMM_J : IMM_I;
        end
        b.ctrl   = c;
        b.rd1    = modelRead(ins[19:15], wrEn, wrAddr, wrData);
        b.rd2    = modelRead(ins[24:20], wrEn, wrAddr, wrData);
        b.immExt = immFor(ins, kind);
        b.rd     = ins[11:7];
        b.rs1    = ins[19:15];
        b.rs2    = ins[24:20];
        return b;
    endfunction

    function automatic instr_t rInstr(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                      funct3_t f3, regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t iInstr(logic [11:0] imm, regAddr_t rs1, funct3_t f3,
                                      regAddr_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t sInstr(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1, funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t bInstr(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t jInstr(logic [20:0] imm, regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic instr_t randomInstr();
        regAddr_t    rd;
        regAddr_t    rs1;
        regAddr_t    rs2;
        funct3_t     f3;
        logic [11:0] imm;
        int unsigned kind;
        rd   = 5'($urandom);
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        imm  = 12'($urandom);
        kind = $urandom_range(7, 0);
        f3   = 3'($urandom_range(7, 0));
        if (f3 == 3'd3)
            f3 = 3'd0;
        case (kind)
            0: return rInstr((f3 == 3'd0 && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd);
            1, 7: begin
                // Shift amounts keep funct7 clear
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm[11:5] = '0;
                return iInstr(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            2: return iInstr(imm, rs1, 3'd2, rd, OPC_LOAD);
            3: return sInstr(imm, rs2, rs1, 3'($urandom_range(2, 0)));
            4: return bInstr(13'($urandom), rs2, rs1);
            5: return jInstr(21'($urandom), rd);
            default: return iInstr(imm, rs1, 3'd0, rd, OPC_JALR);
        endcase
    endfunction

    // Drives on the falling edge and checks combinational outputs once settled
    task automatic presentInstr(string name, instr_t ins, logic wrEn, regAddr_t wrAddr,
                                xlen_t wrData);
        testName    = name;
        instrD_i    = ins;
        regWriteW_i = wrEn;
        rdW_i       = wrAddr;
        resultW_i   = wrData;
        #2;
        checkRegAddr({name, " rs1D"}, ins[19:15], rs1D_o);
        checkRegAddr({name, " rs2D"}, ins[24:20], rs2D_o);
        checkWord({name, " a0"}, modelRead(regAddr_t'(`A0_INDEX), wrEn, wrAddr, wrData), a0_o);
        @(negedge clk);
    endtask

    // Mirror of the pipeline register and register file
    always @(posedge clk) begin
        checkName = testName;
        if (reset_i) begin
            expOut   = '0;
            regModel = '{default: '0};
        end else begin
            if (flushE_i)
                expOut = '0;
            else if (!stallE_i)
                expOut = decodeRef(instrD_i, regWriteW_i, rdW_i, resultW_i);
            if (regWriteW_i && rdW_i != '0)
                regModel[rdW_i] = resultW_i;
        end
    end

    always @(negedge clk) begin
        compareBundle(checkName, expOut, idExE_o);
    end

    initial begin
        #(2 * TOTAL_CYCLES * 10);
        $display("Timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        abortRun();
    end

    initial begin
        logic wrEn;
        void'($urandom(41755));
        reset_i     = 1'b1;
        // A live jump during reset must not reach the bundle
        instrD_i    = jInstr(21'h1FF800, 5'd1);
        resultW_i   = '0;
        rdW_i       = '0;
        regWriteW_i = 1'b0;
        stallE_i    = 1'b0;
        flushE_i    = 1'b0;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        // Fill every register while reading the one being written through the bypass
        for (int r = 0; r < 32; r++) begin
            presentInstr("reg write", rInstr(7'h00, 5'(r - 1), 5'(r), 3'd0, 5'd0),
                         1'b1, 5'(r), (r == 0) ? 32'hFFFF_FFFF : $urandom);
        end
        presentInstr("x0 read", rInstr(7'h00, 5'd0, 5'd10, 3'd0, 5'd1), 1'b0, '0, '0);

        // funct3 3 falls out as unsupported
        for (int f = 0; f < 8; f++) begin
            presentInstr("R-type", rInstr(7'h00, 5'(f + 4), 5'(f + 1), 3'(f), 5'(f + 2)),
                         1'b0, '0, '0);
            presentInstr("I-type", iInstr((f == 1 || f == 5) ? 12'h01F : 12'h8A5, 5'(f + 3),
                         3'(f), 5'(f + 9), OPC_OP_IMM), 1'b0, '0, '0);
        end
        presentInstr("sub", rInstr(7'h20, 5'd7, 5'd6, 3'd0, 5'd8), 1'b0, '0, '0);
        presentInstr("addi pos", iInstr(12'h123, 5'd2, 3'd0, 5'd3, OPC_OP_IMM), 1'b0, '0, '0);
        presentInstr("addi neg", iInstr(12'hFFB, 5'd2, 3'd0, 5'd3, OPC_OP_IMM), 1'b0, '0, '0);
        presentInstr("lw", iInstr(12'hF80, 5'd11, 3'd2, 5'd12, OPC_LOAD), 1'b0, '0, '0);
        presentInstr("sb", sInstr(12'h801, 5'd13, 5'd14, 3'd0), 1'b0, '0, '0);
        presentInstr("sh", sInstr(12'h002, 5'd15, 5'd16, 3'd1), 1'b0, '0, '0);
        presentInstr("sw", sInstr(12'h7FC, 5'd17, 5'd18, 3'd2), 1'b0, '0, '0);
        presentInstr("beq pos", bInstr(13'h0FFE, 5'd19, 5'd20), 1'b0, '0, '0);
        presentInstr("beq neg", bInstr(13'h1FF0, 5'd21, 5'd22), 1'b0, '0, '0);
        presentInstr("jal pos", jInstr(21'h0FFFFE, 5'd1), 1'b0, '0, '0);
        presentInstr("jal neg", jInstr(21'h1FF800, 5'd1), 1'b0, '0, '0);
        presentInstr("jalr", iInstr(12'hFFC, 5'd23, 3'd0, 5'd1, OPC_JALR), 1'b0, '0, '0);
        presentInstr("lui", {20'hABCDE, 5'd7, 7'b0110111}, 1'b0, '0, '0);
        presentInstr("bad store", sInstr(12'h010, 5'd2, 5'd1, 3'd3), 1'b0, '0, '0);

        // Flow control where the held bundle ignores the later write to x3
        presentInstr("capture", iInstr(12'h7FF, 5'd3, 3'd6, 5'd9, OPC_OP_IMM), 1'b0, '0, '0);
        stallE_i = 1'b1;
        presentInstr("stall", sInstr(12'h800, 5'd4, 5'd5, 3'd2), 1'b1, 5'd3, 32'hDEAD_BEEF);
        repeat (2) presentInstr("stall", sInstr(12'h800, 5'd4, 5'd5, 3'd2), 1'b0, '0, '0);
        flushE_i = 1'b1;
        presentInstr("flush over stall", jInstr(21'h000010, 5'd1), 1'b0, '0, '0);
        stallE_i = 1'b0;
        presentInstr("flush", jInstr(21'h000010, 5'd1), 1'b0, '0, '0);
        flushE_i = 1'b0;
        presentInstr("after flush", jInstr(21'h000010, 5'd1), 1'b0, '0, '0);

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            wrEn = 1'($urandom_range(1, 0));
            presentInstr("random", randomInstr(), wrEn, 5'($urandom), $urandom);
        end
        presentInstr("drain", '0, 1'b0, '0, '0);
        @(negedge clk);
        #1;
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
